// File: sources.f
+incdir+.
win_screen_pkg.sv
vga_if.sv
shape_matcher.sv
pixel_painter.sv
win_screen_top.sv
tb_win_screen.sv

// File: tb_win_screen.sv
/* Self-checking testbench for the win screen overlay: drives pixels, predicts the
   painted color from the stroke table and compares the outputs two cycles later. */

`timescale 1ns/1ps
`default_nettype none

`include "win_screen_consts.svh"

module tb_win_screen;

    import win_screen_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;
    localparam int RESET_PIXELS   = 2;
    localparam int BLANK_PIXELS   = 40;
    localparam int EDGE_POSITIONS = 8;
    localparam int EDGE_PIXELS    = EDGE_POSITIONS * 8;
    localparam int ROW_PIXELS     = `WS_RECT_COUNT * 5;
    localparam int RAND_PIXELS    = 2000;
    localparam int TOTAL_PIXELS   = RESET_PIXELS + BLANK_PIXELS + EDGE_PIXELS +
                                    ROW_PIXELS + RAND_PIXELS;

    typedef struct packed {
        int     due;
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
        rgb_t   rgb;
    } exp_rec_t;

    logic   clk;
    logic   rst;
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    rgb_t   rgb;
    coord_t hcount_o;
    coord_t vcount_o;
    logic   hsync_o;
    logic   vsync_o;
    logic   hblnk_o;
    logic   vblnk_o;
    rgb_t   rgb_o;

    exp_rec_t    exp_q [$];
    int          cyc = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          pixel_count = 0;
    int          errors_at_start = 0;
    logic [31:0] seed;

    win_screen_top dut_i (
        .clk      (clk),
        .rst      (rst),
        .hcount   (hcount),
        .vcount   (vcount),
        .hsync    (hsync),
        .vsync    (vsync),
        .hblnk    (hblnk),
        .vblnk    (vblnk),
        .rgb      (rgb),
        .hcount_o (hcount_o),
        .vcount_o (vcount_o),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o),
        .hblnk_o  (hblnk_o),
        .vblnk_o  (vblnk_o),
        .rgb_o    (rgb_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Painter priority over the first covering table row
    function automatic rgb_t expected_rgb(input coord_t h, input coord_t v,
                                          input logic hb, input logic vb, input rgb_t c);
        shape_cls_t cls;
        logic       found;
        cls = SHAPE_NONE;
        found = 1'b0;
        for (int i = 0; i < `WS_RECT_COUNT; i++) begin
            if (!found && v > RECT_TABLE[i].v_lo && v < RECT_TABLE[i].v_hi &&
                h > RECT_TABLE[i].h_lo && h < RECT_TABLE[i].h_hi) begin
                cls = RECT_TABLE[i].cls;
                found = 1'b1;
            end
        end
        if (hb || vb)
            return '0;
        if (v == 0 || v == `WS_V_PIXELS - 1 || h == 0 || h == `WS_H_PIXELS - 1)
            return `WS_PLAYER_COLOR;
        if (cls == SHAPE_LETTER)
            return `WS_PLAYER_COLOR;
        if (cls == SHAPE_OUTLINE)
            return `WS_FRAME_COLOR;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("error at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_outputs_zero();
        check_value("hcount_o", 0, hcount_o);
        check_value("vcount_o", 0, vcount_o);
        check_value("hsync_o", 0, hsync_o);
        check_value("vsync_o", 0, vsync_o);
        check_value("hblnk_o", 0, hblnk_o);
        check_value("vblnk_o", 0, vblnk_o);
        check_value("rgb_o", 0, rgb_o);
    endtask

    // Each record is due two rising edges after the pixel is sampled
    always @(negedge clk) begin
        exp_rec_t e;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            check_value("hcount_o", e.hcount, hcount_o);
            check_value("vcount_o", e.vcount, vcount_o);
            check_value("hsync_o", e.hsync, hsync_o);
            check_value("vsync_o", e.vsync, vsync_o);
            check_value("hblnk_o", e.hblnk, hblnk_o);
            check_value("vblnk_o", e.vblnk, vblnk_o);
            check_value("rgb_o", e.rgb, rgb_o);
        end else if (exp_q.size() > 0 && exp_q[0].due < cyc) begin
            $display("expected pixel for cycle %0d was never compared", exp_q[0].due);
            void'(exp_q.pop_front());
            error_count++;
        end
    end

    task automatic drive_pixel(input coord_t h, input coord_t v, input logic hs,
                               input logic vs, input logic hb, input logic vb,
                               input rgb_t c);
        exp_rec_t e;
        @(posedge clk);
        #(DRIVE_DELAY);
        hcount = h;
        vcount = v;
        hsync = hs;
        vsync = vs;
        hblnk = hb;
        vblnk = vb;
        rgb = c;
        e.due = cyc + 2;
        e.hcount = h;
        e.vcount = v;
        e.hsync = hs;
        e.vsync = vs;
        e.hblnk = hb;
        e.vblnk = vb;
        e.rgb = expected_rgb(h, v, hb, vb, c);
        exp_q.push_back(e);
        pixel_count++;
    endtask

    task automatic draw_random(output logic [31:0] val);
        seed = lcg_next(seed);
        val = seed;
    endtask

    // Half the pixels land near the letters and the button box
    // Low LCG bits repeat with a short period, so flags come from higher bits
    task automatic random_pixel(input logic force_blank);
        logic [31:0] r1;
        logic [31:0] r2;
        coord_t      h;
        coord_t      v;
        logic        hb;
        logic        vb;
        draw_random(r1);
        draw_random(r2);
        if (r1[31]) begin
            h = coord_t'(200 + r1[30:16] % 640);
            v = coord_t'(320 + r2[30:16] % 224);
        end else begin
            h = coord_t'(r1[30:16] % `WS_H_PIXELS);
            v = coord_t'(r2[30:16] % `WS_V_PIXELS);
        end
        if (force_blank) begin
            hb = r1[8];
            vb = ~r1[8] | r1[9];
        end else begin
            hb = (r1[11:8] == 4'd0);
            vb = (r1[15:12] == 4'd0);
        end
        drive_pixel(h, v, r2[12], r2[13], hb, vb, {r2[11:1], r1[2]});
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) @(posedge clk);
        test_count++;
        $display("test %s finished: %0d pixels, %0d errors",
                 name, pixel_count, error_count - errors_at_start);
        pixel_count = 0;
        errors_at_start = error_count;
    endtask

    task automatic run_edge_test();
        logic [31:0] r;
        coord_t      h;
        coord_t      v;
        for (int k = 0; k < EDGE_POSITIONS; k++) begin
            h = coord_t'(50 + k * 120);
            v = coord_t'(40 + k * 90);
            draw_random(r);
            drive_pixel(h, 0, r[12], r[13], 1'b0, 1'b0, r[11:0]);
            drive_pixel(h, `WS_V_PIXELS - 1, r[13], r[12], 1'b0, 1'b0, r[23:12]);
            drive_pixel(0, v, r[14], r[15], 1'b0, 1'b0, r[27:16]);
            drive_pixel(`WS_H_PIXELS - 1, v, r[15], r[14], 1'b0, 1'b0, r[31:20]);
            // One position inside each edge
            drive_pixel(h, 1, r[16], r[17], 1'b0, 1'b0, r[11:0]);
            drive_pixel(h, `WS_V_PIXELS - 2, r[17], r[16], 1'b0, 1'b0, r[23:12]);
            drive_pixel(1, v, r[18], r[19], 1'b0, 1'b0, r[27:16]);
            drive_pixel(`WS_H_PIXELS - 2, v, r[19], r[18], 1'b0, 1'b0, r[31:20]);
        end
    endtask

    // Center of each row, then one pixel on each exclusive bound
    task automatic run_table_test();
        logic [31:0] r;
        rect_t       row;
        coord_t      hc;
        coord_t      vc;
        for (int i = 0; i < `WS_RECT_COUNT; i++) begin
            row = RECT_TABLE[i];
            hc = coord_t'((row.h_lo + row.h_hi) / 2);
            vc = coord_t'((row.v_lo + row.v_hi) / 2);
            draw_random(r);
            drive_pixel(hc, vc, r[12], r[13], 1'b0, 1'b0, r[11:0]);
            drive_pixel(hc, row.v_lo, r[13], r[12], 1'b0, 1'b0, r[23:12]);
            drive_pixel(hc, row.v_hi, r[14], r[15], 1'b0, 1'b0, r[27:16]);
            drive_pixel(row.h_lo, vc, r[15], r[14], 1'b0, 1'b0, r[31:20]);
            drive_pixel(row.h_hi, vc, r[16], r[17], 1'b0, 1'b0, r[19:8]);
        end
    endtask

    initial begin
        rst = 1'b1;
        hcount = 11'd500;
        vcount = 11'd370;
        hsync = 1'b1;
        vsync = 1'b1;
        hblnk = 1'b0;
        vblnk = 1'b0;
        rgb = 12'hABC;
        seed = 32'd2;

        // Reset held over two rising edges, inputs busy meanwhile
        @(negedge clk);
        check_outputs_zero();
        @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        @(negedge clk);
        check_outputs_zero();
        pixel_count = RESET_PIXELS;
        finish_test("reset");

        repeat (BLANK_PIXELS) random_pixel(1'b1);
        finish_test("blanking");

        run_edge_test();
        finish_test("edges");

        run_table_test();
        finish_test("table rows");

        repeat (RAND_PIXELS) random_pixel(1'b0);
        finish_test("random stream");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #((TOTAL_PIXELS + 20) * CLK_PERIOD);
        $display("timeout: the tests did not finish in %0d cycles", TOTAL_PIXELS + 20);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: win_screen_top.sv
/* Win screen overlay for a VGA pixel stream, two cycles from input to output.
   Plain ports outside, a shape lookup stage followed by a painting stage inside. */

`timescale 1ns/1ps
`default_nettype none

module win_screen_top (
    input  logic                   clk,
    input  logic                   rst,
    input  win_screen_pkg::coord_t hcount,
    input  win_screen_pkg::coord_t vcount,
    input  logic                   hsync,
    input  logic                   vsync,
    input  logic                   hblnk,
    input  logic                   vblnk,
    input  win_screen_pkg::rgb_t   rgb,
    output win_screen_pkg::coord_t hcount_o,
    output win_screen_pkg::coord_t vcount_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   hblnk_o,
    output logic                   vblnk_o,
    output win_screen_pkg::rgb_t   rgb_o
);

    import win_screen_pkg::*;

    shape_cls_t shape;

    vga_if pix_in ();
    vga_if pix_mid ();
    vga_if pix_out ();

    assign pix_in.hcount = hcount;
    assign pix_in.vcount = vcount;
    assign pix_in.hsync  = hsync;
    assign pix_in.vsync  = vsync;
    assign pix_in.hblnk  = hblnk;
    assign pix_in.vblnk  = vblnk;
    assign pix_in.rgb    = rgb;

    shape_matcher u_shape_matcher (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (pix_in.in),
        .vga_out (pix_mid.out),
        .shape   (shape)
    );

    pixel_painter u_pixel_painter (
        .clk     (clk),
        .rst     (rst),
        .vga_in  (pix_mid.in),
        .shape   (shape),
        .vga_out (pix_out.out)
    );

    assign hcount_o = pix_out.hcount;
    assign vcount_o = pix_out.vcount;
    assign hsync_o  = pix_out.hsync;
    assign vsync_o  = pix_out.vsync;
    assign hblnk_o  = pix_out.hblnk;
    assign vblnk_o  = pix_out.vblnk;
    assign rgb_o    = pix_out.rgb;

endmodule

`default_nettype wire

// File: pixel_painter.sv
/* Second overlay stage: paints blanking, the screen frame and the strokes.
   Takes the shape class from shape_matcher, aligned with the same pixel. */

`timescale 1ns/1ps
`default_nettype none

`include "win_screen_consts.svh"

module pixel_painter (
    input  logic                       clk,
    input  logic                       rst,
    vga_if.in                          vga_in,
    input  win_screen_pkg::shape_cls_t shape,
    vga_if.out                         vga_out
);

    import win_screen_pkg::*;

    logic blank;
    logic edge_pix;
    rgb_t rgb_nxt;

    assign blank = vga_in.hblnk || vga_in.vblnk;

    // One pixel border of the active area
    assign edge_pix = (vga_in.vcount == coord_t'(0))                  ||
                      (vga_in.vcount == coord_t'(`WS_V_PIXELS - 1))   ||
                      (vga_in.hcount == coord_t'(0))                  ||
                      (vga_in.hcount == coord_t'(`WS_H_PIXELS - 1));

    always_comb begin
        if (blank) begin
            rgb_nxt = '0;
        end else if (edge_pix) begin
            rgb_nxt = `WS_PLAYER_COLOR;
        end else if (shape == SHAPE_LETTER) begin
            rgb_nxt = `WS_PLAYER_COLOR;
        end else if (shape == SHAPE_OUTLINE) begin
            rgb_nxt = `WS_FRAME_COLOR;
        end else begin
            // Background passes through
            rgb_nxt = vga_in.rgb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: shape_matcher.sv
/* First overlay stage: looks up which stroke rectangle covers the pixel.
   Registers the shape class together with the unchanged pixel stream. */

`timescale 1ns/1ps
`default_nettype none

`include "win_screen_consts.svh"

module shape_matcher (
    input  logic                    clk,
    input  logic                    rst,
    vga_if.in                       vga_in,
    vga_if.out                      vga_out,
    output win_screen_pkg::shape_cls_t shape
);

    import win_screen_pkg::*;

    logic [`WS_RECT_COUNT-1:0] hit;
    shape_cls_t                shape_nxt;

    // All rows compared in parallel
    always_comb begin
        for (int i = 0; i < `WS_RECT_COUNT; i++) begin
            hit[i] = rect_hit(RECT_TABLE[i], vga_in.vcount, vga_in.hcount);
        end
    end

    // Walk from the top row down so the lowest hit is the last write
    always_comb begin
        shape_nxt = SHAPE_NONE;
        for (int i = `WS_RECT_COUNT - 1; i >= 0; i--) begin
            if (hit[i]) begin
                shape_nxt = RECT_TABLE[i].cls;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
            shape          <= SHAPE_NONE;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= vga_in.rgb;
            shape          <= shape_nxt;
        end
    end

endmodule

`default_nettype wire

// File: vga_if.sv
/* VGA pixel stream between overlay stages: counts, sync, blanking and color.
   The driving stage takes modport out, the reading stage modport in. */

`timescale 1ns/1ps
`default_nettype none

`include "win_screen_consts.svh"

interface vga_if;

    logic [`WS_COORD_W-1:0] hcount;
    logic [`WS_COORD_W-1:0] vcount;
    logic                   hsync;
    logic                   vsync;
    logic                   hblnk;
    logic                   vblnk;
    logic [`WS_RGB_W-1:0]   rgb;

    modport out (
        output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

    modport in (
        input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb
    );

endinterface

`default_nettype wire

// File: win_screen_pkg.sv
/* Pixel types, shape classes and the stroke rectangle table for the win screen.
   The overlay stages and the testbench import this package. */

`include "win_screen_consts.svh"

package win_screen_pkg;

    typedef logic [`WS_COORD_W-1:0] coord_t;
    typedef logic [`WS_RGB_W-1:0]   rgb_t;

    typedef enum logic [1:0] {
        SHAPE_NONE    = 2'd0,
        SHAPE_LETTER  = 2'd1,
        SHAPE_OUTLINE = 2'd2
    } shape_cls_t;

    // All four bounds are exclusive
    typedef struct packed {
        coord_t     v_lo;
        coord_t     v_hi;
        coord_t     h_lo;
        coord_t     h_hi;
        shape_cls_t cls;
    } rect_t;

    // Row order is priority order, lowest index wins
    localparam rect_t RECT_TABLE [`WS_RECT_COUNT] = '{
        // W
        '{330, 410, 417, 427, SHAPE_LETTER},
        '{390, 400, 427, 437, SHAPE_LETTER},
        '{380, 390, 437, 447, SHAPE_LETTER},
        '{390, 400, 447, 457, SHAPE_LETTER},
        '{330, 410, 457, 467, SHAPE_LETTER},
        // I
        '{330, 410, 477, 487, SHAPE_LETTER},
        // N
        '{330, 410, 497, 507, SHAPE_LETTER},
        '{340, 360, 507, 517, SHAPE_LETTER},
        '{360, 380, 517, 527, SHAPE_LETTER},
        '{380, 400, 527, 537, SHAPE_LETTER},
        '{330, 410, 537, 547, SHAPE_LETTER},
        // S, top bar then down and around
        '{330, 340, 567, 597, SHAPE_LETTER},
        '{340, 360, 557, 567, SHAPE_LETTER},
        '{360, 370, 567, 597, SHAPE_LETTER},
        '{370, 400, 597, 607, SHAPE_LETTER},
        '{400, 410, 567, 597, SHAPE_LETTER},
        '{390, 400, 557, 567, SHAPE_LETTER},
        // Button box: top, left, right, bottom
        '{430, 435, 237, 787, SHAPE_OUTLINE},
        '{430, 530, 237, 242, SHAPE_OUTLINE},
        '{430, 530, 782, 787, SHAPE_OUTLINE},
        '{525, 530, 237, 787, SHAPE_OUTLINE}
    };

    // Strict containment on both axes
    function automatic logic rect_hit(rect_t r, coord_t vcount, coord_t hcount);
        return (vcount > r.v_lo) && (vcount < r.v_hi) &&
               (hcount > r.h_lo) && (hcount < r.h_hi);
    endfunction

endpackage

// File: win_screen_consts.svh
/* Shared widths, screen geometry and colors for the win screen overlay.
   Include wherever the macros are needed; the guard makes repeats harmless. */

`ifndef WIN_SCREEN_CONSTS_SVH
`define WIN_SCREEN_CONSTS_SVH

// Pixel counter width
`define WS_COORD_W 11

// 4-4-4 color value
`define WS_RGB_W 12

// Active area
`define WS_H_PIXELS 1024
`define WS_V_PIXELS 768

// Frame edge and WINS letters
`define WS_PLAYER_COLOR 12'hF00

// Button box outline
`define WS_FRAME_COLOR 12'h00F

// Letter strokes plus outline strokes
`define WS_RECT_COUNT 21

`endif
